// File: verilog/lat_pkg.sv
// Shared definitions for the latency scoreboard
// Field widths, request-type codes, per-type delay ranges and FIFO sizing
// RTL files refer to these by scoped name, never by import

package lat_pkg;

   // Field widths
   localparam int TYPE_W = 3;
   localparam int ADDR_W = 13;
   localparam int META_W = TYPE_W + ADDR_W;
   localparam int DATA_W = 32;
   localparam int TID_W  = 16;

   // Request type, top bits of meta
   typedef enum logic [TYPE_W-1:0] {
      RDLINE  = 3'd0,
      WRLINE  = 3'd1,
      WRTHRU  = 3'd2,
      WRFENCE = 3'd3,
      INTR    = 3'd4
   } req_type_e;

   // One tracked request, 64 bits
   typedef struct packed {
      logic [TID_W-1:0]  tid;
      logic [META_W-1:0] meta;
      logic [DATA_W-1:0] data;
   } payload_t;

   // Slot countdown width, holds the largest maximum
   localparam int CNT_W = 6;

   // Delay ranges in cycles
   localparam int RDLINE_LAT_MIN = 4;
   localparam int RDLINE_LAT_MAX = 20;
   localparam int WRLINE_LAT_MIN = 2;
   localparam int WRLINE_LAT_MAX = 12;
   localparam int WRTHRU_LAT_MIN = 2;
   localparam int WRTHRU_LAT_MAX = 8;
   localparam int INTR_LAT_MIN   = 6;
   localparam int INTR_LAT_MAX   = 30;
   localparam int LAT_UNDEFINED  = 10;

   // Fixed pipeline cycles on an empty path
   localparam int PIPE_LAT_MIN = 6;

   // Latency slots
   localparam int NUM_SLOTS = 8;
   localparam int SLOT_W    = 3;

   // FIFO sizing
   localparam int IN_DEPTH_LOG2  = 4;
   localparam int IN_FULL_THRESH = 12;
   localparam int Q_DEPTH_LOG2   = 3;
   localparam int Q_FULL_THRESH  = 5;
   localparam int COUNT_W        = 8;

   localparam logic [15:0] LFSR_SEED = 16'hACE1;

endpackage

// File: verilog/lat_fifo.sv
// Synchronous FIFO used for every stage of the scoreboard
// Head is shown combinationally and a push is visible after its edge
// Overflow and underflow pulse for one cycle on a rejected push or pop

`timescale 1ns/1ps

module lat_fifo #(
   parameter type payload_t   = lat_pkg::payload_t,
   parameter int  DEPTH_LOG2  = 3,
   parameter int  FULL_THRESH = 5
) (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        push_i,
   input  payload_t                    data_i,
   input  logic                        pop_i,
   output payload_t                    data_o,
   output logic                        valid_o,
   output logic                        empty_o,
   output logic                        almfull_o,
   output logic [lat_pkg::COUNT_W-1:0] count_o,
   output logic                        overflow_o,
   output logic                        underflow_o
);

   localparam int DEPTH = 2 ** DEPTH_LOG2;

   payload_t              mem [DEPTH];
   logic [DEPTH_LOG2-1:0] wr_ptr;
   logic [DEPTH_LOG2-1:0] rd_ptr;
   logic [DEPTH_LOG2:0]   count;
   logic                  full;
   logic                  do_push;
   logic                  do_pop;

   assign full    = (count == DEPTH[DEPTH_LOG2:0]);
   assign empty_o = (count == '0);
   assign valid_o = !empty_o;
   // Rejected requests only raise the error flags
   assign do_push = push_i && !full;
   assign do_pop  = pop_i && !empty_o;

   assign data_o    = mem[rd_ptr];
   assign almfull_o = (count >= FULL_THRESH[DEPTH_LOG2:0]);
   assign count_o   = lat_pkg::COUNT_W'(count);

   // Storage
   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= data_i;
      end
   end

   // Pointers, occupancy and error pulses
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr      <= '0;
         rd_ptr      <= '0;
         count       <= '0;
         overflow_o  <= 1'b0;
         underflow_o <= 1'b0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // Simultaneous push and pop leaves the count alone
         if (do_push && !do_pop) begin
            count <= count + 1'b1;
         end else if (do_pop && !do_push) begin
            count <= count - 1'b1;
         end
         overflow_o  <= push_i && full;
         underflow_o <= pop_i && empty_o;
      end
   end

   // Occupancy stays within the depth and matches the pointer distance
   a_count_bound : assert property (@(posedge clk) disable iff (rst)
      count <= DEPTH[DEPTH_LOG2:0] &&
      count[DEPTH_LOG2-1:0] == DEPTH_LOG2'(wr_ptr - rd_ptr));

endmodule

// File: verilog/fence_gate.sv
// Write-fence gate between the input FIFO and the filtered FIFO
// Ordinary requests move across with a one-cycle registered push
// A fence holds the head until every later stage is empty, then is dropped

`timescale 1ns/1ps

module fence_gate (
   input  logic              clk,
   input  logic              rst,
   input  logic              in_valid_i,
   input  lat_pkg::payload_t in_data_i,
   input  logic              q_almfull_i,
   input  logic              drained_i,
   output logic              in_pop_o,
   output logic              q_push_o,
   output lat_pkg::payload_t q_data_o
);

   typedef enum logic [1:0] {
      G_PASS,
      G_WAIT_DRAIN,
      G_SETTLE
   } gate_state_e;

   gate_state_e state;
   logic        head_fence;

   // Fence code sits in the top bits of meta
   assign head_fence = in_valid_i &&
      (in_data_i.meta[lat_pkg::META_W-1 -: lat_pkg::TYPE_W] == lat_pkg::WRFENCE);

   // Pass on room, or drop the fence once in settle
   always_comb begin
      case (state)
         G_PASS:   in_pop_o = in_valid_i && !head_fence && !q_almfull_i;
         G_SETTLE: in_pop_o = head_fence;
         default:  in_pop_o = 1'b0;
      endcase
   end

   // Fence trap FSM
   always_ff @(posedge clk) begin
      if (rst) begin
         state <= G_PASS;
      end else begin
         case (state)
            G_PASS:       if (head_fence) state <= G_WAIT_DRAIN;
            G_WAIT_DRAIN: if (drained_i) state <= G_SETTLE;
            default:      state <= G_PASS;
         endcase
      end
   end

   // Registered push that a settle pop never reaches
   always_ff @(posedge clk) begin
      if (rst) begin
         q_push_o <= 1'b0;
      end else begin
         q_push_o <= in_pop_o && state == G_PASS;
      end
   end

   always_ff @(posedge clk) begin
      q_data_o <= in_data_i;
   end

   // The trapped fence is still at the head when it is dropped
   a_fence_held : assert property (@(posedge clk) disable iff (rst)
      state == G_SETTLE |-> head_fence);

endmodule

// File: verilog/delay_gen.sv
// Pseudo-random delay source for the latency slots
// A 16-bit maximal-length LFSR steps once per slot load
// Delay is the type's minimum plus the LFSR value folded into its range

`timescale 1ns/1ps

module delay_gen (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      advance_i,
   input  lat_pkg::req_type_e        req_type_i,
   output logic [lat_pkg::CNT_W-1:0] delay_o
);

   logic [15:0] lfsr;
   int          lo;
   int          span;

   // Taps 16, 14, 13, 11
   always_ff @(posedge clk) begin
      if (rst) begin
         lfsr <= lat_pkg::LFSR_SEED;
      end else if (advance_i) begin
         lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      end
   end

   // Range per type with a single fixed value for unknown codes
   always_comb begin
      case (req_type_i)
         lat_pkg::RDLINE: lo = lat_pkg::RDLINE_LAT_MIN;
         lat_pkg::WRLINE: lo = lat_pkg::WRLINE_LAT_MIN;
         lat_pkg::WRTHRU: lo = lat_pkg::WRTHRU_LAT_MIN;
         lat_pkg::INTR:   lo = lat_pkg::INTR_LAT_MIN;
         default:         lo = lat_pkg::LAT_UNDEFINED;
      endcase
      case (req_type_i)
         lat_pkg::RDLINE: span = lat_pkg::RDLINE_LAT_MAX - lo + 1;
         lat_pkg::WRLINE: span = lat_pkg::WRLINE_LAT_MAX - lo + 1;
         lat_pkg::WRTHRU: span = lat_pkg::WRTHRU_LAT_MAX - lo + 1;
         lat_pkg::INTR:   span = lat_pkg::INTR_LAT_MAX - lo + 1;
         default:         span = 1;
      endcase
   end

   assign delay_o = lat_pkg::CNT_W'(lo + int'(lfsr) % span);

   // LFSR never locks at zero, and the folded value fits the range
   a_delay_range : assert property (@(posedge clk) disable iff (rst)
      lfsr != '0 &&
      (!advance_i || (int'(delay_o) >= lo && int'(delay_o) < lo + span)));

endmodule

// File: verilog/latency_slots.sv
// Latency slot array of the scoreboard
// The lowest free slot takes the filtered FIFO head with a random delay
// Each slot counts down, then waits as ready until it is released
// The lowest ready slot goes out through a pop register into the output FIFO
// Release stalls while the output FIFO is almost full

`timescale 1ns/1ps

module latency_slots (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        q_valid_i,
   input  lat_pkg::payload_t           q_data_i,
   input  logic                        out_almfull_i,
   output logic                        q_pop_o,
   output logic                        out_push_o,
   output lat_pkg::payload_t           out_data_o,
   output logic                        empty_o,
   output logic [lat_pkg::COUNT_W-1:0] occupied_o
);

   localparam int N = lat_pkg::NUM_SLOTS;

   typedef enum logic [1:0] {
      S_FREE,
      S_COUNT,
      S_READY,
      S_POPPED
   } slot_state_e;

   slot_state_e                 slot_state [N];
   logic [lat_pkg::CNT_W-1:0]   slot_cnt   [N];
   lat_pkg::payload_t           slot_data  [N];

   logic                        free_found;
   logic [lat_pkg::SLOT_W-1:0]  free_idx;
   logic                        ready_found;
   logic [lat_pkg::SLOT_W-1:0]  ready_idx;
   logic                        release_now;
   logic [N-1:0]                load_vec;
   logic [N-1:0]                rel_vec;
   logic [lat_pkg::CNT_W-1:0]   delay;

   // Lowest free and lowest ready slot by a downward scan
   always_comb begin
      free_found  = 1'b0;
      free_idx    = '0;
      ready_found = 1'b0;
      ready_idx   = '0;
      for (int i = N - 1; i >= 0; i--) begin
         if (slot_state[i] == S_FREE) begin
            free_found = 1'b1;
            free_idx   = lat_pkg::SLOT_W'(i);
         end
         if (slot_state[i] == S_READY) begin
            ready_found = 1'b1;
            ready_idx   = lat_pkg::SLOT_W'(i);
         end
      end
   end

   // Take the head whenever a slot is free
   assign q_pop_o     = q_valid_i && free_found;
   assign release_now = ready_found && !out_almfull_i;

   // Delay for the request being loaded in the same cycle
   delay_gen i_delay_gen (
      .clk        (clk),
      .rst        (rst),
      .advance_i  (q_pop_o),
      .req_type_i (lat_pkg::req_type_e'(q_data_i.meta[lat_pkg::META_W-1 -: lat_pkg::TYPE_W])),
      .delay_o    (delay)
   );

   for (genvar g = 0; g < N; g++) begin : g_slot
      assign load_vec[g] = q_pop_o && free_idx == lat_pkg::SLOT_W'(g);
      assign rel_vec[g]  = release_now && ready_idx == lat_pkg::SLOT_W'(g);

      // Slot FSM with a countdown of delay+1 cycles
      always_ff @(posedge clk) begin
         if (rst) begin
            slot_state[g] <= S_FREE;
            slot_cnt[g]   <= '0;
         end else begin
            case (slot_state[g])
               S_FREE: begin
                  if (load_vec[g]) begin
                     slot_state[g] <= S_COUNT;
                     slot_cnt[g]   <= delay;
                  end
               end
               S_COUNT: begin
                  if (slot_cnt[g] == '0) begin
                     slot_state[g] <= S_READY;
                  end else begin
                     slot_cnt[g] <= slot_cnt[g] - 1'b1;
                  end
               end
               S_READY: begin
                  if (rel_vec[g]) slot_state[g] <= S_POPPED;
               end
               // Pop register pushes this cycle
               default: slot_state[g] <= S_FREE;
            endcase
         end
      end

      // Payload captured on load
      always_ff @(posedge clk) begin
         if (load_vec[g]) begin
            slot_data[g] <= q_data_i;
         end
      end
   end

   // Pop register towards the output FIFO
   always_ff @(posedge clk) begin
      if (rst) begin
         out_push_o <= 1'b0;
      end else begin
         out_push_o <= release_now;
      end
   end

   always_ff @(posedge clk) begin
      out_data_o <= slot_data[ready_idx];
   end

   // Occupancy where popped slots still count until pushed
   always_comb begin
      occupied_o = '0;
      for (int i = 0; i < N; i++) begin
         occupied_o = occupied_o + lat_pkg::COUNT_W'(slot_state[i] != S_FREE);
      end
   end

   assign empty_o = (occupied_o == '0);

   // At most one slot leaves the free state per cycle
   a_single_load : assert property (@(posedge clk) disable iff (rst)
      occupied_o <= $past(occupied_o) + 1'b1);

endmodule

// File: verilog/latency_scoreboard.sv
// Top level of the latency-modelling scoreboard
// Requests are tagged, queued, fence-filtered, delayed in slots and queued out
// Writer watches full_o, reader drains with valid_o and read_en_i
// count_o is the total number of requests held anywhere inside

`timescale 1ns/1ps

module latency_scoreboard (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        write_en_i,
   input  logic [lat_pkg::META_W-1:0]  meta_i,
   input  logic [lat_pkg::DATA_W-1:0]  data_i,
   input  logic                        read_en_i,
   output logic [lat_pkg::TID_W-1:0]   tid_o,
   output logic [lat_pkg::META_W-1:0]  meta_o,
   output logic [lat_pkg::DATA_W-1:0]  data_o,
   output logic                        valid_o,
   output logic                        empty_o,
   output logic                        full_o,
   output logic                        overflow_o,
   output logic                        underflow_o,
   output logic [lat_pkg::COUNT_W-1:0] count_o
);

   logic [lat_pkg::TID_W-1:0]   tid_cnt;
   lat_pkg::payload_t           in_payload;
   logic                        in_valid;
   logic                        in_pop;
   logic [lat_pkg::COUNT_W-1:0] in_count;
   logic                        in_ovf;
   logic                        in_unf;
   lat_pkg::payload_t           gate_data;
   logic                        gate_push;
   lat_pkg::payload_t           q_payload;
   logic                        q_valid;
   logic                        q_pop;
   logic                        q_empty;
   logic                        q_almfull;
   logic [lat_pkg::COUNT_W-1:0] q_count;
   logic                        q_ovf;
   logic                        q_unf;
   lat_pkg::payload_t           slot_data;
   logic                        slot_push;
   logic                        slots_empty;
   logic [lat_pkg::COUNT_W-1:0] slots_occ;
   lat_pkg::payload_t           out_payload;
   logic                        out_almfull;
   logic [lat_pkg::COUNT_W-1:0] out_count;
   logic                        out_ovf;
   logic                        out_unf;
   logic                        drained;

   // Every write takes the next tracking ID, fences included
   always_ff @(posedge clk) begin
      if (rst) begin
         tid_cnt <= '0;
      end else if (write_en_i) begin
         tid_cnt <= tid_cnt + 1'b1;
      end
   end

   // Input FIFO, almost-full is the external full
   lat_fifo #(
      .payload_t   (lat_pkg::payload_t),
      .DEPTH_LOG2  (lat_pkg::IN_DEPTH_LOG2),
      .FULL_THRESH (lat_pkg::IN_FULL_THRESH)
   ) i_in_fifo (
      .clk         (clk),
      .rst         (rst),
      .push_i      (write_en_i),
      .data_i      ({tid_cnt, meta_i, data_i}),
      .pop_i       (in_pop),
      .data_o      (in_payload),
      .valid_o     (in_valid),
      .empty_o     (),
      .almfull_o   (full_o),
      .count_o     (in_count),
      .overflow_o  (in_ovf),
      .underflow_o (in_unf)
   );

   // Fence drain needs every later stage empty
   assign drained = q_empty && slots_empty && empty_o;

   fence_gate i_fence_gate (
      .clk         (clk),
      .rst         (rst),
      .in_valid_i  (in_valid),
      .in_data_i   (in_payload),
      .q_almfull_i (q_almfull),
      .drained_i   (drained),
      .in_pop_o    (in_pop),
      .q_push_o    (gate_push),
      .q_data_o    (gate_data)
   );

   // Filtered FIFO, fences removed
   lat_fifo #(
      .payload_t   (lat_pkg::payload_t),
      .DEPTH_LOG2  (lat_pkg::Q_DEPTH_LOG2),
      .FULL_THRESH (lat_pkg::Q_FULL_THRESH)
   ) i_q_fifo (
      .clk         (clk),
      .rst         (rst),
      .push_i      (gate_push),
      .data_i      (gate_data),
      .pop_i       (q_pop),
      .data_o      (q_payload),
      .valid_o     (q_valid),
      .empty_o     (q_empty),
      .almfull_o   (q_almfull),
      .count_o     (q_count),
      .overflow_o  (q_ovf),
      .underflow_o (q_unf)
   );

   latency_slots i_latency_slots (
      .clk           (clk),
      .rst           (rst),
      .q_valid_i     (q_valid),
      .q_data_i      (q_payload),
      .out_almfull_i (out_almfull),
      .q_pop_o       (q_pop),
      .out_push_o    (slot_push),
      .out_data_o    (slot_data),
      .empty_o       (slots_empty),
      .occupied_o    (slots_occ)
   );

   // Output FIFO drained by the consumer
   lat_fifo #(
      .payload_t   (lat_pkg::payload_t),
      .DEPTH_LOG2  (lat_pkg::Q_DEPTH_LOG2),
      .FULL_THRESH (lat_pkg::Q_FULL_THRESH)
   ) i_out_fifo (
      .clk         (clk),
      .rst         (rst),
      .push_i      (slot_push),
      .data_i      (slot_data),
      .pop_i       (read_en_i),
      .data_o      (out_payload),
      .valid_o     (valid_o),
      .empty_o     (empty_o),
      .almfull_o   (out_almfull),
      .count_o     (out_count),
      .overflow_o  (out_ovf),
      .underflow_o (out_unf)
   );

   assign tid_o  = out_payload.tid;
   assign meta_o = out_payload.meta;
   assign data_o = out_payload.data;

   // Status roll-up
   assign overflow_o  = in_ovf || q_ovf || out_ovf;
   assign underflow_o = in_unf || q_unf || out_unf;
   assign count_o     = in_count + q_count + slots_occ + out_count;

endmodule

// File: tb/latency_scoreboard_tb.sv
// Testbench for the latency scoreboard
// Replays request and stall records from the stimulus file on the falling edge
// Reference model per tracking ID checks values, fence order, latency and status

`timescale 1ns/1ps

module latency_scoreboard_tb;

   localparam int    MAX_REC   = 256;
   localparam string STIM_FILE = "tb/scoreboard_stimulus.txt";

   logic                        clk;
   logic                        rst;
   logic                        write_en_i;
   logic [lat_pkg::META_W-1:0]  meta_i;
   logic [lat_pkg::DATA_W-1:0]  data_i;
   logic                        read_en_i;
   logic [lat_pkg::TID_W-1:0]   tid_o;
   logic [lat_pkg::META_W-1:0]  meta_o;
   logic [lat_pkg::DATA_W-1:0]  data_o;
   logic                        valid_o;
   logic                        empty_o;
   logic                        full_o;
   logic                        overflow_o;
   logic                        underflow_o;
   logic [lat_pkg::COUNT_W-1:0] count_o;

   // Stimulus records of kind R for a request and S for a read stall
   byte                        rec_kind [MAX_REC];
   int                         rec_type [MAX_REC];
   int                         rec_addr [MAX_REC];
   logic [lat_pkg::DATA_W-1:0] rec_data [MAX_REC];
   int                         rec_len  [MAX_REC];
   int                         num_rec;

   // Reference model indexed by tracking ID
   logic [lat_pkg::META_W-1:0] exp_meta    [MAX_REC];
   logic [lat_pkg::DATA_W-1:0] exp_data    [MAX_REC];
   int                         wr_cycle    [MAX_REC];
   bit                         is_fence    [MAX_REC];
   bit                         seen        [MAX_REC];
   // Requests in front of each fence still not out
   int                         pend_before [MAX_REC];

   int cycle;
   int limit;
   int writes;
   int nonfence_written;
   int received;
   int err_value;
   int err_order;
   int err_latency;
   int err_status;

   latency_scoreboard i_dut (
      .clk         (clk),
      .rst         (rst),
      .write_en_i  (write_en_i),
      .meta_i      (meta_i),
      .data_i      (data_i),
      .read_en_i   (read_en_i),
      .tid_o       (tid_o),
      .meta_o      (meta_o),
      .data_o      (data_o),
      .valid_o     (valid_o),
      .empty_o     (empty_o),
      .full_o      (full_o),
      .overflow_o  (overflow_o),
      .underflow_o (underflow_o),
      .count_o     (count_o)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk) cycle <= cycle + 1;

   // Minimum delay per request type in cycles
   function automatic int type_min_latency(input int req_type);
      case (req_type)
         0:       return 4;
         1:       return 2;
         2:       return 2;
         4:       return 6;
         default: return 10;
      endcase
   endfunction

   task automatic load_stimulus();
      int    fd;
      int    n;
      string line;
      byte   kind;
      fd = $fopen(STIM_FILE, "r");
      if (fd == 0) begin
         $display("Cannot open the stimulus file %s", STIM_FILE);
         err_status++;
         return;
      end
      while (!$feof(fd) && num_rec < MAX_REC) begin
         n = $fgets(line, fd);
         // Skip blank and comment lines
         if (n > 1 && line[0] != "#") begin
            n = $sscanf(line, "%c", kind);
            rec_kind[num_rec] = kind;
            if (kind == "R") begin
               n = $sscanf(line, "%c %d %h %h %d", kind, rec_type[num_rec],
                           rec_addr[num_rec], rec_data[num_rec], rec_len[num_rec]);
            end else begin
               n = $sscanf(line, "%c %d", kind, rec_len[num_rec]);
            end
            num_rec++;
         end
      end
      $fclose(fd);
   endtask

   // One write tagged with the ID the DUT is expected to give it
   task automatic drive_write(input int idx);
      logic [lat_pkg::META_W-1:0] meta;
      meta = {lat_pkg::TYPE_W'(rec_type[idx]), lat_pkg::ADDR_W'(rec_addr[idx])};
      write_en_i = 1'b1;
      meta_i     = meta;
      data_i     = rec_data[idx];
      exp_meta[writes] = meta;
      exp_data[writes] = rec_data[idx];
      // The write is taken at the next rising edge
      wr_cycle[writes] = cycle + 1;
      is_fence[writes] = (rec_type[idx] == 3);
      if (is_fence[writes]) begin
         pend_before[writes] = nonfence_written - received;
      end else begin
         nonfence_written++;
      end
      writes++;
   endtask

   // Check the head item that the next rising edge consumes
   task automatic check_output();
      int tid;
      int lat;
      int min_lat;
      bit ok_tid;
      tid    = int'(tid_o);
      ok_tid = tid < writes;
      if (ok_tid) ok_tid = !is_fence[tid] && !seen[tid];
      assert (ok_tid) else begin
         err_value++;
         $display("Output tid %0d was never written, is a fence or came out twice", tid);
      end
      if (ok_tid) begin
         seen[tid] = 1'b1;
         received++;
         assert (meta_o == exp_meta[tid]) else begin
            err_value++;
            $display("[ERROR] conservation meta tid %0d: expected %h actual %h",
                     tid, exp_meta[tid], meta_o);
         end
         assert (data_o == exp_data[tid]) else begin
            err_value++;
            $display("[ERROR] conservation data tid %0d: expected %h actual %h",
                     tid, exp_data[tid], data_o);
         end
         lat     = cycle - wr_cycle[tid];
         min_lat = type_min_latency(int'(exp_meta[tid][lat_pkg::META_W-1 -: lat_pkg::TYPE_W]))
                   + lat_pkg::PIPE_LAT_MIN;
         assert (lat >= min_lat) else begin
            err_latency++;
            $display("[ERROR] min latency tid %0d: expected >= %0d actual %0d",
                     tid, min_lat, lat);
         end
         // Nothing behind a fence may pass anything in front of it
         for (int f = 0; f < writes; f++) begin
            if (is_fence[f]) begin
               if (tid < f) begin
                  pend_before[f]--;
               end else begin
                  assert (pend_before[f] == 0) else begin
                     err_order++;
                     $display("[ERROR] fence order tid %0d past fence %0d: expected 0 actual %0d",
                              tid, f, pend_before[f]);
                  end
               end
            end
         end
      end
   endtask

   initial begin : watchdog
      wait (limit > 0 && cycle > limit);
      $display("Timeout at cycle %0d with %0d of %0d requests still inside",
               cycle, nonfence_written - received, nonfence_written);
      $display("Errors: value %0d, order %0d, latency %0d, status %0d",
               err_value, err_order, err_latency, err_status);
      $display("test failed");
      $finish;
   end

   initial begin
      int ptr;
      int gap_left;
      int stall_left;
      int nreq;
      int slack;
      bit saw_full;
      rst        = 1'b1;
      write_en_i = 1'b0;
      meta_i     = '0;
      data_i     = '0;
      read_en_i  = 1'b0;
      ptr        = 0;
      gap_left   = 0;
      stall_left = 0;
      nreq       = 0;
      slack      = 0;
      saw_full   = 1'b0;
      load_stimulus();
      for (int i = 0; i < num_rec; i++) begin
         slack = slack + rec_len[i];
         if (rec_kind[i] == "R") nreq++;
      end
      limit = slack + nreq * (lat_pkg::INTR_LAT_MAX + lat_pkg::PIPE_LAT_MIN + 8) + 200;

      repeat (5) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      assert (!valid_o && !full_o && !overflow_o && !underflow_o && empty_o && count_o == '0)
      else begin
         err_status++;
         $display("[ERROR] after reset: expected v0 f0 o0 u0 e1 c0 actual v%b f%b o%b u%b e%b c%0d",
                  valid_o, full_o, overflow_o, underflow_o, empty_o, count_o);
      end

      while (!(ptr == num_rec && received == nonfence_written && stall_left == 0)) begin
         @(negedge clk);
         assert (!overflow_o && !underflow_o) else begin
            err_status++;
            $display("[ERROR] status flags: expected o0 u0 actual o%b u%b",
                     overflow_o, underflow_o);
         end
         if (stall_left > 0 && full_o) saw_full = 1'b1;
         // Reader takes the head unless stalled
         read_en_i = valid_o && stall_left == 0;
         if (read_en_i) check_output();
         if (stall_left > 0) stall_left--;
         // Writer steps through the records and holds off on full
         write_en_i = 1'b0;
         if (gap_left > 0) begin
            gap_left--;
         end else if (ptr < num_rec) begin
            if (rec_kind[ptr] == "S") begin
               stall_left = rec_len[ptr];
               ptr++;
            end else if (!full_o) begin
               drive_write(ptr);
               gap_left = rec_len[ptr];
               ptr++;
            end
         end
      end

      @(negedge clk);
      read_en_i = 1'b0;
      assert (empty_o && !valid_o && count_o == '0) else begin
         err_status++;
         $display("[ERROR] drain: expected e1 v0 c0 actual e%b v%b c%0d",
                  empty_o, valid_o, count_o);
      end
      assert (saw_full) else begin
         err_status++;
         $display("The long read stall never raised full_o");
      end

      $display("Errors: value %0d, order %0d, latency %0d, status %0d",
               err_value, err_order, err_latency, err_status);
      if (err_value + err_order + err_latency + err_status == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

// File: tb/scoreboard_stimulus.txt
# R <type> <addr hex> <data hex> <gap>  request, type 3 is a write fence
# S <cycles>  hold read_en_i low while later records go on
R 0 0010 11110000 0
R 1 0020 22220001 1
R 2 0030 33330002 0
R 4 0040 44440003 2
R 3 0000 00000000 0
R 0 0050 55550004 0
R 2 0060 66660005 3
R 6 0070 77770006 0
R 1 0080 88880007 0
R 3 0000 00000000 0
R 4 0090 99990008 1
R 0 00a0 aaaa0009 0
S 12
R 2 00b0 bbbb000a 0
R 1 00c0 cccc000b 4
S 80
R 0 0100 c0de0000 0
R 1 0101 c0de0001 0
R 2 0102 c0de0002 0
R 4 0103 c0de0003 0
R 0 0104 c0de0004 0
R 1 0105 c0de0005 0
R 2 0106 c0de0006 0
R 4 0107 c0de0007 0
R 0 0108 c0de0008 0
R 1 0109 c0de0009 0
R 2 010a c0de000a 0
R 4 010b c0de000b 0
R 0 010c c0de000c 0
R 1 010d c0de000d 0
R 2 010e c0de000e 0
R 4 010f c0de000f 0
R 0 0110 c0de0010 0
R 1 0111 c0de0011 0
R 2 0112 c0de0012 0
R 4 0113 c0de0013 0
R 0 0114 c0de0014 0
R 1 0115 c0de0015 0
R 2 0116 c0de0016 0
R 4 0117 c0de0017 0
R 0 0118 c0de0018 0
R 1 0119 c0de0019 0
R 2 011a c0de001a 0
R 4 011b c0de001b 0
R 0 011c c0de001c 0
R 1 011d c0de001d 0
R 2 011e c0de001e 0
R 4 011f c0de001f 0
R 0 0120 c0de0020 0
R 7 0121 c0de0021 0
R 3 0000 00000000 0
R 4 0130 f00d0000 0
R 1 0131 f00d0001 0

// File: verilog.f
verilog/lat_pkg.sv
verilog/lat_fifo.sv
verilog/fence_gate.sv
verilog/delay_gen.sv
verilog/latency_slots.sv
verilog/latency_scoreboard.sv
tb/latency_scoreboard_tb.sv

// File: Makefile
# Verilator build and run of the latency scoreboard testbench

VERILATOR ?= verilator
TOP       ?= latency_scoreboard_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert
PASS_MSG  ?= test passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
